/* src/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and address width
`define CORE_XLEN 32

// architectural registers, x0 included
`define CORE_REGS 32

// data memory depth in words, power of two so addresses wrap cleanly
`define CORE_DMEM_WORDS 64

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

/* src/isa_pkg.sv */
`default_nettype none

`include "core_defs.svh"

package isa_pkg;

	// data, addresses and instructions
	typedef logic [`CORE_XLEN-1:0] word_t;

	// register index
	typedef logic [$clog2(`CORE_REGS)-1:0] reg_idx_t;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011
	} opcode_e;

	// alu operations
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLT = 4'd5,
		ALU_SLL = 4'd6,
		ALU_SRL = 4'd7
	} alu_op_e;

endpackage

`default_nettype wire

/* src/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

	// control bundle from decode, all clear means bubble
	typedef struct packed {
		isa_pkg::alu_op_e alu_op;
		logic             use_imm;
		logic             mem_read;
		logic             mem_write;
		logic             reg_write;
		logic             is_branch;
	} ctrl_t;

	typedef struct packed {
		logic           valid;
		isa_pkg::word_t pc;
		isa_pkg::word_t instr;
	} if_id_t;

	typedef struct packed {
		logic              valid;
		isa_pkg::word_t    pc;
		ctrl_t             ctrl;
		isa_pkg::reg_idx_t rs1;
		isa_pkg::reg_idx_t rs2;
		isa_pkg::reg_idx_t rd;
		isa_pkg::word_t    rs1_val;
		isa_pkg::word_t    rs2_val;
		isa_pkg::word_t    imm;
	} id_ex_t;

	typedef struct packed {
		logic              valid;
		ctrl_t             ctrl;
		isa_pkg::reg_idx_t rd;
		isa_pkg::word_t    alu_result;
		isa_pkg::word_t    store_data;
	} ex_mem_t;

	// result already selected between load data and alu output
	typedef struct packed {
		logic              valid;
		logic              reg_write;
		isa_pkg::reg_idx_t rd;
		isa_pkg::word_t    result;
	} mem_wb_t;

	// operand source for execute
	typedef enum logic [1:0] {
		FWD_NONE = 2'b00,
		FWD_MEM  = 2'b01,
		FWD_WB   = 2'b10
	} fwd_sel_e;

endpackage

`default_nettype wire

/* src/decoder.sv */
`default_nettype none

`include "core_defs.svh"

module decoder (
	input  isa_pkg::word_t    instr_i,
	output pipe_pkg::ctrl_t   ctrl_o,
	output isa_pkg::word_t    imm_o,
	output isa_pkg::reg_idx_t rs1_o,
	output isa_pkg::reg_idx_t rs2_o,
	output isa_pkg::reg_idx_t rd_o
);

	logic [2:0]     funct3;
	logic           funct7_b5;
	logic           funct7_ok;
	isa_pkg::word_t imm_i_type;
	isa_pkg::word_t imm_s_type;
	isa_pkg::word_t imm_b_type;

	assign funct3    = instr_i[14:12];
	assign funct7_b5 = instr_i[30];
	// only bit 5 of funct7 may be set in the register form
	assign funct7_ok = ({instr_i[31], instr_i[29:25]} == '0);

	assign rs1_o = instr_i[19:15];
	assign rs2_o = instr_i[24:20];
	assign rd_o  = instr_i[11:7];

	assign imm_i_type = {{(`CORE_XLEN-12){instr_i[31]}}, instr_i[31:20]};
	assign imm_s_type = {{(`CORE_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b_type = {{(`CORE_XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
		instr_i[30:25], instr_i[11:8], 1'b0};

	always_comb begin
		ctrl_o        = '0;
		ctrl_o.alu_op = isa_pkg::ALU_ADD;
		imm_o         = imm_i_type;
		case (isa_pkg::opcode_e'(instr_i[6:0]))
			isa_pkg::OPC_OP: begin
				ctrl_o.reg_write = funct7_ok;
				case ({funct7_b5, funct3})
					4'b0_000: ctrl_o.alu_op = isa_pkg::ALU_ADD;
					4'b1_000: ctrl_o.alu_op = isa_pkg::ALU_SUB;
					4'b0_111: ctrl_o.alu_op = isa_pkg::ALU_AND;
					4'b0_110: ctrl_o.alu_op = isa_pkg::ALU_OR;
					4'b0_100: ctrl_o.alu_op = isa_pkg::ALU_XOR;
					4'b0_010: ctrl_o.alu_op = isa_pkg::ALU_SLT;
					4'b0_001: ctrl_o.alu_op = isa_pkg::ALU_SLL;
					4'b0_101: ctrl_o.alu_op = isa_pkg::ALU_SRL;
					default:  ctrl_o.reg_write = 1'b0;
				endcase
			end
			isa_pkg::OPC_OP_IMM: begin
				ctrl_o.use_imm   = 1'b1;
				ctrl_o.reg_write = 1'b1;
				case (funct3)
					3'b000:  ctrl_o.alu_op = isa_pkg::ALU_ADD;
					3'b111:  ctrl_o.alu_op = isa_pkg::ALU_AND;
					3'b110:  ctrl_o.alu_op = isa_pkg::ALU_OR;
					3'b100:  ctrl_o.alu_op = isa_pkg::ALU_XOR;
					3'b010:  ctrl_o.alu_op = isa_pkg::ALU_SLT;
					// immediate shifts and sltiu are not supported
					default: ctrl_o = '0;
				endcase
			end
			isa_pkg::OPC_LOAD: begin
				if (funct3 == 3'b010) begin
					ctrl_o.use_imm   = 1'b1;
					ctrl_o.mem_read  = 1'b1;
					ctrl_o.reg_write = 1'b1;
				end
			end
			isa_pkg::OPC_STORE: begin
				imm_o = imm_s_type;
				if (funct3 == 3'b010) begin
					ctrl_o.use_imm   = 1'b1;
					ctrl_o.mem_write = 1'b1;
				end
			end
			isa_pkg::OPC_BRANCH: begin
				imm_o = imm_b_type;
				// beq compares through a subtract and the zero flag
				if (funct3 == 3'b000) begin
					ctrl_o.alu_op    = isa_pkg::ALU_SUB;
					ctrl_o.is_branch = 1'b1;
				end
			end
			default: ctrl_o = '0;
		endcase
		// writes to x0 are dropped here, so nothing downstream sees them
		if (rd_o == '0)
			ctrl_o.reg_write = 1'b0;
	end

endmodule

`default_nettype wire

/* src/regfile.sv */
`default_nettype none

`include "core_defs.svh"

module regfile (
	input  logic              clk,
	input  logic              rst_n,
	input  isa_pkg::reg_idx_t rs1_i,
	input  isa_pkg::reg_idx_t rs2_i,
	output isa_pkg::word_t    rs1_data_o,
	output isa_pkg::word_t    rs2_data_o,
	input  logic              we_i,
	input  isa_pkg::reg_idx_t rd_i,
	input  isa_pkg::word_t    rd_data_i
);

	// x0 has no storage
	isa_pkg::word_t regs [1:`CORE_REGS-1];

	// same-cycle write wins over the stored value
	function automatic isa_pkg::word_t read_port(input isa_pkg::reg_idx_t idx);
		if (idx == '0)
			return '0;
		if (we_i && rd_i == idx)
			return rd_data_i;
		return regs[idx];
	endfunction

	always_comb begin
		rs1_data_o = read_port(rs1_i);
		rs2_data_o = read_port(rs2_i);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < `CORE_REGS; i++)
				regs[i] <= '0;
		end else if (we_i && rd_i != '0) begin
			regs[rd_i] <= rd_data_i;
		end
	end

	// decode clears the write enable for rd x0, so x0 never changes
	assert property (@(posedge clk) disable iff (!rst_n) we_i |-> rd_i != '0)
		else $error("regfile write aimed at x0");

endmodule

`default_nettype wire

/* src/alu.sv */
`default_nettype none

`include "core_defs.svh"

module alu (
	input  isa_pkg::word_t   a_i,
	input  isa_pkg::word_t   b_i,
	input  isa_pkg::alu_op_e op_i,
	output isa_pkg::word_t   result_o,
	output logic             zero_o
);

	logic [$clog2(`CORE_XLEN)-1:0] shamt;

	assign shamt = b_i[$clog2(`CORE_XLEN)-1:0];

	always_comb begin
		case (op_i)
			isa_pkg::ALU_ADD: result_o = a_i + b_i;
			isa_pkg::ALU_SUB: result_o = a_i - b_i;
			isa_pkg::ALU_AND: result_o = a_i & b_i;
			isa_pkg::ALU_OR:  result_o = a_i | b_i;
			isa_pkg::ALU_XOR: result_o = a_i ^ b_i;
			// signed compare, result is 0 or 1
			isa_pkg::ALU_SLT: result_o = isa_pkg::word_t'($signed(a_i) < $signed(b_i));
			isa_pkg::ALU_SLL: result_o = a_i << shamt;
			isa_pkg::ALU_SRL: result_o = a_i >> shamt;
			default:          result_o = '0;
		endcase
	end

	// beq decision
	assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

/* src/data_mem.sv */
`default_nettype none

`include "core_defs.svh"

module data_mem (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           read_i,
	input  logic           write_i,
	input  isa_pkg::word_t addr_i,
	input  isa_pkg::word_t wdata_i,
	output isa_pkg::word_t rdata_o
);

	localparam int IDX_W = $clog2(`CORE_DMEM_WORDS);

	isa_pkg::word_t   mem [`CORE_DMEM_WORDS];
	logic [IDX_W-1:0] idx;

	// word index, upper address bits wrap
	assign idx = addr_i[IDX_W+1:2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CORE_DMEM_WORDS; i++)
				mem[i] <= '0;
		end else if (write_i) begin
			mem[idx] <= wdata_i;
		end
	end

	assign rdata_o = read_i ? mem[idx] : '0;

	// one memory instruction per cycle, and never both lw and sw at once
	assert property (@(posedge clk) disable iff (!rst_n) !(read_i && write_i))
		else $error("data memory read and write in the same cycle");

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
`default_nettype none

module hazard_unit (
	input  isa_pkg::reg_idx_t  id_rs1_i,
	input  isa_pkg::reg_idx_t  id_rs2_i,
	input  isa_pkg::reg_idx_t  ex_rs1_i,
	input  isa_pkg::reg_idx_t  ex_rs2_i,
	input  logic               ex_mem_read_i,
	input  logic               mem_reg_write_i,
	input  logic               wb_reg_write_i,
	input  isa_pkg::reg_idx_t  ex_rd_i,
	input  isa_pkg::reg_idx_t  mem_rd_i,
	input  isa_pkg::reg_idx_t  wb_rd_i,
	input  logic               branch_taken_i,
	output pipe_pkg::fwd_sel_e fwd_a_o,
	output pipe_pkg::fwd_sel_e fwd_b_o,
	output logic               stall_o,
	output logic               flush_o
);

	logic load_use;

	// memory stage is younger than writeback, so it is checked first
	function automatic pipe_pkg::fwd_sel_e pick_source(
		input isa_pkg::reg_idx_t src,
		input logic              mem_we,
		input isa_pkg::reg_idx_t mem_rd,
		input logic              wb_we,
		input isa_pkg::reg_idx_t wb_rd
	);
		if (mem_we && mem_rd != '0 && mem_rd == src)
			return pipe_pkg::FWD_MEM;
		if (wb_we && wb_rd != '0 && wb_rd == src)
			return pipe_pkg::FWD_WB;
		return pipe_pkg::FWD_NONE;
	endfunction

	assign fwd_a_o = pick_source(ex_rs1_i, mem_reg_write_i, mem_rd_i, wb_reg_write_i, wb_rd_i);
	assign fwd_b_o = pick_source(ex_rs2_i, mem_reg_write_i, mem_rd_i, wb_reg_write_i, wb_rd_i);

	// load result only exists after the memory stage
	assign load_use = ex_mem_read_i && ex_rd_i != '0
		&& (ex_rd_i == id_rs1_i || ex_rd_i == id_rs2_i);

	assign flush_o = branch_taken_i;
	// flush wins in the stage registers of the core
	assign stall_o = load_use;

	// execute holds one instruction, never a load and a taken branch together
	always_comb begin
		assert final (!(stall_o && flush_o))
			else $error("stall and flush in the same cycle");
	end

endmodule

`default_nettype wire

/* src/core.sv */
`default_nettype none

`include "core_defs.svh"

module core (
	input  logic              clk,
	input  logic              rst_n,
	output isa_pkg::word_t    imem_addr_o,
	input  isa_pkg::word_t    imem_data_i,
	output logic              wb_valid_o,
	output isa_pkg::reg_idx_t wb_rd_o,
	output isa_pkg::word_t    wb_data_o
);

	isa_pkg::word_t     pc;
	pipe_pkg::if_id_t   if_id;
	pipe_pkg::id_ex_t   id_ex;
	pipe_pkg::ex_mem_t  ex_mem;
	pipe_pkg::mem_wb_t  mem_wb;

	pipe_pkg::ctrl_t    dec_ctrl;
	pipe_pkg::ctrl_t    id_ctrl;
	isa_pkg::word_t     dec_imm;
	isa_pkg::reg_idx_t  dec_rs1;
	isa_pkg::reg_idx_t  dec_rs2;
	isa_pkg::reg_idx_t  dec_rd;
	isa_pkg::word_t     rs1_val;
	isa_pkg::word_t     rs2_val;

	pipe_pkg::fwd_sel_e fwd_a;
	pipe_pkg::fwd_sel_e fwd_b;
	isa_pkg::word_t     op_a;
	isa_pkg::word_t     op_b;
	isa_pkg::word_t     alu_out;
	logic               alu_zero;
	logic               branch_taken;
	isa_pkg::word_t     branch_target;
	logic               stall;
	logic               flush;

	isa_pkg::word_t     mem_rdata;
	isa_pkg::word_t     mem_result;

	function automatic isa_pkg::word_t fwd_mux(
		input pipe_pkg::fwd_sel_e sel,
		input isa_pkg::word_t     reg_val,
		input isa_pkg::word_t     mem_val,
		input isa_pkg::word_t     wb_val
	);
		case (sel)
			pipe_pkg::FWD_MEM: return mem_val;
			pipe_pkg::FWD_WB:  return wb_val;
			default:           return reg_val;
		endcase
	endfunction

	// fetch
	assign imem_addr_o = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= `CORE_RESET_PC;
		else if (flush)
			pc <= branch_target;
		else if (!stall)
			pc <= pc + 4;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			if_id <= '0;
		else if (flush)
			if_id.valid <= 1'b0;
		else if (!stall)
			if_id <= '{valid: 1'b1, pc: pc, instr: imem_data_i};
	end

	// decode
	decoder decoder_inst (
		.instr_i(if_id.instr),
		.ctrl_o (dec_ctrl),
		.imm_o  (dec_imm),
		.rs1_o  (dec_rs1),
		.rs2_o  (dec_rs2),
		.rd_o   (dec_rd)
	);

	regfile regfile_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.rs1_i     (dec_rs1),
		.rs2_i     (dec_rs2),
		.rs1_data_o(rs1_val),
		.rs2_data_o(rs2_val),
		.we_i      (wb_valid_o),
		.rd_i      (mem_wb.rd),
		.rd_data_i (mem_wb.result)
	);

	// an empty decode slot carries no enables into execute
	assign id_ctrl = if_id.valid ? dec_ctrl : pipe_pkg::ctrl_t'(0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else if (flush || stall) begin
			id_ex <= '0;
		end else begin
			id_ex <= '{valid: if_id.valid, pc: if_id.pc, ctrl: id_ctrl, rs1: dec_rs1,
				rs2: dec_rs2, rd: dec_rd, rs1_val: rs1_val, rs2_val: rs2_val, imm: dec_imm};
		end
	end

	// execute
	hazard_unit hazard_unit_inst (
		.id_rs1_i       (dec_rs1),
		.id_rs2_i       (dec_rs2),
		.ex_rs1_i       (id_ex.rs1),
		.ex_rs2_i       (id_ex.rs2),
		.ex_mem_read_i  (id_ex.valid & id_ex.ctrl.mem_read),
		.mem_reg_write_i(ex_mem.valid & ex_mem.ctrl.reg_write),
		.wb_reg_write_i (mem_wb.valid & mem_wb.reg_write),
		.ex_rd_i        (id_ex.rd),
		.mem_rd_i       (ex_mem.rd),
		.wb_rd_i        (mem_wb.rd),
		.branch_taken_i (branch_taken),
		.fwd_a_o        (fwd_a),
		.fwd_b_o        (fwd_b),
		.stall_o        (stall),
		.flush_o        (flush)
	);

	assign op_a = fwd_mux(fwd_a, id_ex.rs1_val, ex_mem.alu_result, mem_wb.result);
	assign op_b = fwd_mux(fwd_b, id_ex.rs2_val, ex_mem.alu_result, mem_wb.result);

	alu alu_inst (
		.a_i     (op_a),
		.b_i     (id_ex.ctrl.use_imm ? id_ex.imm : op_b),
		.op_i    (id_ex.ctrl.alu_op),
		.result_o(alu_out),
		.zero_o  (alu_zero)
	);

	assign branch_taken  = id_ex.valid & id_ex.ctrl.is_branch & alu_zero;
	assign branch_target = id_ex.pc + id_ex.imm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ex_mem <= '0;
		else
			ex_mem <= '{valid: id_ex.valid, ctrl: id_ex.ctrl, rd: id_ex.rd,
				alu_result: alu_out, store_data: op_b};
	end

	// memory
	data_mem data_mem_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.read_i (ex_mem.valid & ex_mem.ctrl.mem_read),
		.write_i(ex_mem.valid & ex_mem.ctrl.mem_write),
		.addr_i (ex_mem.alu_result),
		.wdata_i(ex_mem.store_data),
		.rdata_o(mem_rdata)
	);

	assign mem_result = ex_mem.ctrl.mem_read ? mem_rdata : ex_mem.alu_result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mem_wb <= '0;
		else
			mem_wb <= '{valid: ex_mem.valid, reg_write: ex_mem.ctrl.reg_write,
				rd: ex_mem.rd, result: mem_result};
	end

	// writeback and retire trace
	assign wb_valid_o = mem_wb.valid & mem_wb.reg_write;
	assign wb_rd_o    = mem_wb.rd;
	assign wb_data_o  = mem_wb.result;

	// decode drops rd x0 writes, and the pipeline must keep it that way
	assert property (@(posedge clk) disable iff (!rst_n) wb_valid_o |-> wb_rd_o != '0)
		else $error("retire reported for x0");

endmodule

`default_nettype wire

/* bench/iss_model.svh */
`ifndef ISS_MODEL_SVH
`define ISS_MODEL_SVH

isa_pkg::word_t    prog [PROG_LEN];
isa_pkg::reg_idx_t exp_rd [$];
isa_pkg::word_t    exp_data [$];

// funct3 pools, register form without sltu and immediate form without shifts
localparam logic [20:0] R_F3 = {3'b111, 3'b110, 3'b101, 3'b100, 3'b010, 3'b001, 3'b000};
localparam logic [14:0] I_F3 = {3'b111, 3'b110, 3'b100, 3'b010, 3'b000};

function automatic isa_pkg::reg_idx_t rand_reg();
	return isa_pkg::reg_idx_t'(rand_below(8));
endfunction

// few data words, each reachable through several wrapped aliases
function automatic logic [11:0] mem_offset(input int word);
	return 12'((word + `CORE_DMEM_WORDS * rand_below(8)) * 4);
endfunction

function automatic isa_pkg::word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
	input isa_pkg::reg_idx_t rd, input isa_pkg::reg_idx_t rs1, input logic [11:0] imm);
	return {imm, rs1, f3, rd, opc};
endfunction

task automatic build_program();
	int i;
	int kind;
	int target;
	int word;
	isa_pkg::reg_idx_t rd;
	isa_pkg::reg_idx_t rs1;
	isa_pkg::reg_idx_t rs2;
	logic [2:0] f3;
	logic [11:0] off;
	logic [12:0] boff;
	i = 0;
	while (i < PROG_LEN - 1) begin
		kind = rand_below(10);
		rd = rand_reg();
		rs1 = rand_reg();
		rs2 = rand_reg();
		if (kind < 3) begin
			f3 = R_F3[3*rand_below(7) +: 3];
			prog[i] = {(f3 == 3'b000 && rand_below(2) == 1) ? 7'h20 : 7'h00,
				rs2, rs1, f3, rd, 7'b0110011};
		end else if (kind < 6) begin
			f3 = I_F3[3*rand_below(5) +: 3];
			prog[i] = enc_i(7'b0010011, f3, rd, rs1, 12'(rand_below(4096)));
		end else if (kind == 6) begin
			prog[i] = enc_i(7'b0000011, 3'b010, rd, 5'd0, mem_offset(rand_below(4)));
		end else if (kind == 7) begin
			off = mem_offset(rand_below(4));
			prog[i] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
		end else if (kind == 8) begin
			target = i + 1 + rand_below(4);
			if (target > PROG_LEN - 1)
				target = PROG_LEN - 1;
			if (rand_below(2) == 1)
				rs2 = rs1;
			boff = 13'((target - i) * 4);
			prog[i] = {boff[12], boff[10:5], rs2, rs1, 3'b000, boff[4:1], boff[11], 7'b1100011};
		end else if (i + 3 <= PROG_LEN - 1) begin
			// store, aliased load, then an immediate use of the loaded value
			word = rand_below(4);
			off = mem_offset(word);
			prog[i] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
			i++;
			prog[i] = enc_i(7'b0000011, 3'b010, rd, 5'd0, mem_offset(word));
			i++;
			prog[i] = {7'h00, rs1, rd, 3'b000, rand_reg(), 7'b0110011};
		end else begin
			prog[i] = enc_i(7'b0010011, 3'b000, rd, 5'd0, 12'(rand_below(4096)));
		end
		i++;
	end
	prog[PROG_LEN-1] = SELF_LOOP;
endtask

function automatic isa_pkg::word_t model_alu(input logic [2:0] f3, input logic sub,
	input isa_pkg::word_t a, input isa_pkg::word_t b);
	case (f3)
		3'b000: return sub ? a - b : a + b;
		3'b001: return a << b[4:0];
		3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'b100: return a ^ b;
		3'b101: return a >> b[4:0];
		3'b110: return a | b;
		default: return a & b;
	endcase
endfunction

// architectural run, records every nonzero-rd write in order
task automatic run_model();
	isa_pkg::word_t x [32];
	isa_pkg::word_t dm [`CORE_DMEM_WORDS];
	isa_pkg::word_t ins;
	isa_pkg::word_t imm;
	isa_pkg::word_t res;
	isa_pkg::word_t boff;
	int pc_idx;
	int next;
	int steps;
	logic wr;
	logic running;
	foreach (x[k])
		x[k] = '0;
	foreach (dm[k])
		dm[k] = '0;
	pc_idx = 0;
	steps = 0;
	running = 1'b1;
	while (running && steps < 4 * PROG_LEN) begin
		ins = prog[pc_idx];
		imm = {{20{ins[31]}}, ins[31:20]};
		wr = 1'b0;
		res = '0;
		next = pc_idx + 1;
		case (ins[6:0])
			7'b0110011: begin
				res = model_alu(ins[14:12], ins[30], x[ins[19:15]], x[ins[24:20]]);
				wr = 1'b1;
			end
			7'b0010011: begin
				res = model_alu(ins[14:12], 1'b0, x[ins[19:15]], imm);
				wr = 1'b1;
			end
			7'b0000011: begin
				res = dm[((x[ins[19:15]] + imm) >> 2) % `CORE_DMEM_WORDS];
				wr = 1'b1;
			end
			7'b0100011: begin
				imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
				dm[((x[ins[19:15]] + imm) >> 2) % `CORE_DMEM_WORDS] = x[ins[24:20]];
			end
			default: begin
				boff = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
				if (x[ins[19:15]] == x[ins[24:20]]) begin
					if (boff == '0)
						running = 1'b0;
					next = pc_idx + int'(boff >> 2);
				end
			end
		endcase
		if (wr && ins[11:7] != 5'd0) begin
			x[ins[11:7]] = res;
			exp_rd.push_back(ins[11:7]);
			exp_data.push_back(res);
		end
		pc_idx = next;
		steps++;
	end
endtask

`endif

/* bench/core_tb.sv */
`default_nettype none

`include "core_defs.svh"

module core_tb;

	localparam int CLK_PERIOD     = 20;
	localparam int DRIVE_DELAY    = 2;
	localparam int RESET_CYCLES   = 8;
	localparam int PROG_LEN       = 120;
	localparam int DRAIN_CYCLES   = 10;
	// worst case a little under three cycles per instruction plus pipeline fill
	localparam int TIMEOUT_CYCLES = 3 * PROG_LEN + 40;
	localparam logic [31:0] SEED  = 32'd62;
	// beq x0, x0, 0
	localparam isa_pkg::word_t SELF_LOOP = 32'h0000_0063;

	logic              clk;
	logic              rst_n;
	isa_pkg::word_t    imem_addr;
	isa_pkg::word_t    imem_data;
	logic              wb_valid;
	isa_pkg::reg_idx_t wb_rd;
	isa_pkg::word_t    wb_data;

	logic [31:0] lcg_state;
	int          seen;
	int          run_cycles;

	core core_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr_o(imem_addr),
		.imem_data_i(imem_data),
		.wb_valid_o (wb_valid),
		.wb_rd_o    (wb_rd),
		.wb_data_o  (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// upper bits only, the low bits of an lcg cycle quickly
	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = lcg_next();
		return int'(r[31:16]) % n;
	endfunction

	`include "iss_model.svh"

	// instruction memory, anything past the program is the self-loop
	assign imem_data = ((imem_addr >> 2) < PROG_LEN) ? prog[imem_addr >> 2] : SELF_LOOP;

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "run stopped");
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR: %s expected 0x%08h actual 0x%08h", name, expected, actual);
			report_failure("retire trace mismatch");
		end
	endtask

	initial begin
		run_cycles = 0;
		forever begin
			@(posedge clk);
			if (rst_n)
				run_cycles++;
			if (run_cycles >= TIMEOUT_CYCLES)
				report_failure("timeout waiting for the expected register writes to retire");
		end
	end

	initial begin
		rst_n = 1'b0;
		seen = 0;
		lcg_state = SEED;
		build_program();
		run_model();
		$display("program of %0d words, %0d register writes expected",
			PROG_LEN, exp_rd.size());
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_equal("wb_valid_o", 32'd0, 32'(wb_valid));
			check_equal("imem_addr_o", `CORE_RESET_PC, imem_addr);
		end
		@(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		while (seen < exp_rd.size()) begin
			@(negedge clk);
			if (wb_valid) begin
				check_equal("wb_rd_o", 32'(exp_rd[seen]), 32'(wb_rd));
				check_equal("wb_data_o", exp_data[seen], wb_data);
				seen++;
			end
		end
		// only the self-loop is left, it writes nothing
		repeat (DRAIN_CYCLES) begin
			@(negedge clk);
			if (wb_valid)
				report_failure("retire pulse after the last expected register write");
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
+incdir+bench
src/isa_pkg.sv
src/pipe_pkg.sv
src/decoder.sv
src/regfile.sv
src/alu.sv
src/data_mem.sv
src/hazard_unit.sv
src/core.sv
bench/core_tb.sv

/* Bender.yml */
package:
  name: rv32i_pipe_core

sources:
  - include_dirs:
      - src
    files:
      - src/isa_pkg.sv
      - src/pipe_pkg.sv
      - src/decoder.sv
      - src/regfile.sv
      - src/alu.sv
      - src/data_mem.sv
      - src/hazard_unit.sv
      - src/core.sv
  - target: test
    include_dirs:
      - src
      - bench
    files:
      - bench/core_tb.sv
